/* sim.f */
+incdir+bench
common/cpu_pkg.sv
hdl/status_seq.sv
hdl/ins_fetch.sv
hdl/ins_dec.sv
hdl/reg_file.sv
hdl/mem_access.sv
hdl/ins_exec.sv
hdl/ctl_unit.sv
bench/tb_ctl_unit.sv

/* Bender.yml */
package:
  name: ctl_unit

sources:
  - files:
      - common/cpu_pkg.sv
      - hdl/status_seq.sv
      - hdl/ins_fetch.sv
      - hdl/ins_dec.sv
      - hdl/reg_file.sv
      - hdl/mem_access.sv
      - hdl/ins_exec.sv
      - hdl/ctl_unit.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_ctl_unit.sv

/* bench/tb_asm.svh */
`ifndef TB_ASM_SVH
`define TB_ASM_SVH

// word access size for LW and SW
localparam logic [2:0] F3_WORD = 3'b010;
// jump opcode, not handled by the core
localparam logic [6:0] OPC_JAL = 7'b1101111;

function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] funct3,
                                      input logic [4:0] rd, input logic [6:0] opcode);
    return {funct7, rs2, rs1, funct3, rd, opcode};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] funct3, input logic [4:0] rd,
                                      input logic [6:0] opcode);
    return {imm, rs1, funct3, rd, opcode};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] funct3,
                                      input logic [6:0] opcode);
    return {imm[11:5], rs2, rs1, funct3, imm[4:0], opcode};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opcode);
    return {imm, rd, opcode};
endfunction

// upper part for LUI, rounded so a following ADDI lands on v
function automatic logic [19:0] const_hi(input logic [31:0] v);
    logic [31:0] t;
    t = v + 32'h800;
    return t[31:12];
endfunction

// taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

/* bench/tb_ctl_unit.sv */
`timescale 1ns/1ps

module tb_ctl_unit;

    import cpu_pkg::*;

    `include "tb_asm.svh"

    typedef enum logic [4:0] {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_SLL, K_SRL,
        K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLTI, K_SLLI, K_SRLI,
        K_CONST, K_LOAD, K_X0, K_BAD
    } kind_t;

    typedef struct packed {
        kind_t           kind;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] exp;
    } case_t;

    localparam int NUM_KINDS = 19;
    localparam int NUM_CASES = 2 * NUM_KINDS;
    localparam int PROG_LEN  = 6;
    localparam int MEM_WORDS = 1024;
    localparam logic [XLEN-1:0] DATA_ADDR = 32'h100;
    localparam logic [XLEN-1:0] LOAD_BASE = 32'h200;
    localparam int WATCHDOG_NS = NUM_CASES * PROG_LEN * 11 * 10 * 2;

    logic            sys_clk   = 1'b0;
    logic            sys_rst   = 1'b1;
    logic [XLEN-1:0] mem_rdata = '0;
    mem_req_t        mem_req;

    logic [XLEN-1:0] mem [MEM_WORDS];
    logic [31:0]     lfsr_state = 32'h3dce;
    case_t           cases [NUM_CASES];

    ctl_unit uut (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req)
    );

    initial begin
        forever #5 sys_clk = ~sys_clk;
    end

    // memory model, read data one cycle after the request
    always @(posedge sys_clk) begin
        if (mem_req.en && !mem_req.we) begin
            mem_rdata <= mem[mem_req.addr[11:2]];
        end
        if (mem_req.en && mem_req.we) begin
            mem[mem_req.addr[11:2]] <= mem_req.wdata;
        end
    end

    // ==============================
    // helpers
    // ==============================

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [XLEN-1:0] sext12(input logic [11:0] v);
        return {{(XLEN-12){v[11]}}, v};
    endfunction

    function automatic logic [XLEN-1:0] expect_result(input kind_t k, input logic [XLEN-1:0] a,
                                                      input logic [XLEN-1:0] b);
        case (k)
            K_ADD, K_ADDI: return a + b;
            K_SUB:         return a - b;
            K_AND, K_ANDI: return a & b;
            K_OR, K_ORI:   return a | b;
            K_XOR, K_XORI: return a ^ b;
            K_SLT, K_SLTI: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_SLL, K_SLLI: return a << b[4:0];
            K_SRL, K_SRLI: return a >> b[4:0];
            K_X0:          return '0;
            default:       return a;
        endcase
    endfunction

    // instruction under test, x3 = x1 op x2 or x1 op imm
    function automatic logic [31:0] test_word(input case_t c);
        case (c.kind)
            K_ADD:   return enc_r(7'h00, 5'd2, 5'd1, F3_ADD, 5'd3, OPC_OP);
            K_SUB:   return enc_r(7'h20, 5'd2, 5'd1, F3_ADD, 5'd3, OPC_OP);
            K_AND:   return enc_r(7'h00, 5'd2, 5'd1, F3_AND, 5'd3, OPC_OP);
            K_OR:    return enc_r(7'h00, 5'd2, 5'd1, F3_OR, 5'd3, OPC_OP);
            K_XOR:   return enc_r(7'h00, 5'd2, 5'd1, F3_XOR, 5'd3, OPC_OP);
            K_SLT:   return enc_r(7'h00, 5'd2, 5'd1, F3_SLT, 5'd3, OPC_OP);
            K_SLL:   return enc_r(7'h00, 5'd2, 5'd1, F3_SLL, 5'd3, OPC_OP);
            K_SRL:   return enc_r(7'h00, 5'd2, 5'd1, F3_SRL, 5'd3, OPC_OP);
            K_ADDI:  return enc_i(c.b[11:0], 5'd1, F3_ADD, 5'd3, OPC_OP_IMM);
            K_ANDI:  return enc_i(c.b[11:0], 5'd1, F3_AND, 5'd3, OPC_OP_IMM);
            K_ORI:   return enc_i(c.b[11:0], 5'd1, F3_OR, 5'd3, OPC_OP_IMM);
            K_XORI:  return enc_i(c.b[11:0], 5'd1, F3_XOR, 5'd3, OPC_OP_IMM);
            K_SLTI:  return enc_i(c.b[11:0], 5'd1, F3_SLT, 5'd3, OPC_OP_IMM);
            K_SLLI:  return enc_i(c.b[11:0], 5'd1, F3_SLL, 5'd3, OPC_OP_IMM);
            K_SRLI:  return enc_i(c.b[11:0], 5'd1, F3_SRL, 5'd3, OPC_OP_IMM);
            K_LOAD:  return enc_i(c.b[11:0], 5'd1, F3_WORD, 5'd3, OPC_LOAD);
            K_X0:    return enc_r(7'h00, 5'd2, 5'd1, F3_ADD, 5'd0, OPC_OP);
            K_BAD:   return enc_u(20'habcde, 5'd3, OPC_JAL);
            default: return enc_i(12'd0, 5'd0, F3_ADD, 5'd0, OPC_OP_IMM);
        endcase
    endfunction

    task automatic load_program(input case_t c);
        logic [4:0]      reg_a;
        logic [4:0]      src;
        logic [XLEN-1:0] ld_addr;
        // constant and bad-opcode cases build their value straight into x3
        reg_a   = (c.kind == K_CONST || c.kind == K_BAD) ? 5'd3 : 5'd1;
        src     = (c.kind == K_X0) ? 5'd0 : 5'd3;
        ld_addr = c.a + c.b;
        mem[0] = enc_u(const_hi(c.a), reg_a, OPC_LUI);
        mem[1] = enc_i(c.a[11:0], reg_a, F3_ADD, reg_a, OPC_OP_IMM);
        mem[2] = enc_u(const_hi(c.b), 5'd2, OPC_LUI);
        mem[3] = enc_i(c.b[11:0], 5'd2, F3_ADD, 5'd2, OPC_OP_IMM);
        mem[4] = test_word(c);
        mem[5] = enc_s(DATA_ADDR[11:0], src, 5'd0, F3_WORD, OPC_STORE);
        if (c.kind == K_LOAD) begin
            mem[ld_addr[11:2]] = c.exp;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_req(input string name, input mem_req_t got, input mem_req_t exp);
        if (got.addr !== exp.addr) begin
            abort_run($sformatf("** Error at %0t: %s.addr = %h, expected %h",
                                $time, name, got.addr, exp.addr));
        end
        if (got.wdata !== exp.wdata) begin
            abort_run($sformatf("** Error at %0t: %s.wdata = %h, expected %h",
                                $time, name, got.wdata, exp.wdata));
        end
    endtask

    task automatic run_case(input int idx, input case_t c);
        mem_req_t        exp_req;
        logic [XLEN-1:0] fetch_pc;
        int              loads;
        bit              stored;
        fetch_pc = RESET_PC;
        loads    = 0;
        stored   = 1'b0;
        @(posedge sys_clk);
        sys_rst <= 1'b1;
        load_program(c);
        repeat (10) @(posedge sys_clk);
        sys_rst <= 1'b0;
        // program fetches sit below the data area
        while (!stored) begin
            @(negedge sys_clk);
            exp_req = '0;
            if (mem_req.en && mem_req.we) begin
                exp_req.addr  = DATA_ADDR;
                exp_req.wdata = c.exp;
                check_req("mem_req", mem_req, exp_req);
                stored = 1'b1;
            end else if (mem_req.en && mem_req.addr < DATA_ADDR) begin
                exp_req.addr = fetch_pc;
                check_req("mem_req", mem_req, exp_req);
                fetch_pc += 4;
            end else if (mem_req.en) begin
                exp_req.addr = c.a + c.b;
                check_req("mem_req", mem_req, exp_req);
                loads++;
            end
        end
        if (fetch_pc != PROG_LEN * 4) begin
            abort_run($sformatf("case %0d: store came after %0d fetches instead of %0d",
                                idx, fetch_pc / 4, PROG_LEN));
        end
        if (loads != ((c.kind == K_LOAD) ? 1 : 0)) begin
            abort_run($sformatf("case %0d: wrong number of data reads (%0d)", idx, loads));
        end
    endtask

    // ==============================
    // case table and main loop
    // ==============================

    initial begin
        kind_t       k;
        logic [11:0] imm12;
        for (int i = 0; i < NUM_CASES; i++) begin
            k             = kind_t'(i % NUM_KINDS);
            cases[i].kind = k;
            cases[i].a    = take_bits(32);
            imm12         = 12'(take_bits(12));
            case (k)
                K_SLLI, K_SRLI: cases[i].b = take_bits(5);
                K_ADDI:         cases[i].b = sext12(imm12 | 12'h800);
                K_ANDI, K_ORI, K_XORI, K_SLTI: cases[i].b = sext12(imm12);
                K_LOAD: begin
                    cases[i].a = LOAD_BASE;
                    cases[i].b = take_bits(4) << 2;
                end
                default:        cases[i].b = take_bits(32);
            endcase
            if (k == K_LOAD) begin
                cases[i].exp = take_bits(32);
            end else begin
                cases[i].exp = expect_result(k, cases[i].a, cases[i].b);
            end
        end
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i, cases[i]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, no store arrived", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

endmodule

/* hdl/ctl_unit.sv */
`timescale 1ns/1ps

module ctl_unit (
    input  logic                      sys_clk,
    input  logic                      sys_rst,
    input  logic [cpu_pkg::XLEN-1:0]  mem_rdata,
    output cpu_pkg::mem_req_t         mem_req
);

    import cpu_pkg::*;

    status_t               status;
    logic [7:0]            stage_done;

    logic                  fetch_done;
    logic                  dec_done;
    logic                  reg_r_done;
    logic                  mem_r_done;
    logic                  exec_done;
    logic                  reg_w_done;
    logic                  mem_w_done;
    logic                  pc_done;

    mem_req_t              fetch_req;
    ins_word_u             ins;
    logic [REG_IDX_W-1:0]  rs1;
    logic [REG_IDX_W-1:0]  rs2;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    dec_t                  dec;
    logic [XLEN-1:0]       load_val;
    wb_t                   wb;
    st_rec_t               store;

    // done bits indexed by status
    assign stage_done[ST_INS_FETCH] = fetch_done;
    assign stage_done[ST_INS_DEC]   = dec_done;
    assign stage_done[ST_REG_R]     = reg_r_done;
    assign stage_done[ST_MEM_R]     = mem_r_done;
    assign stage_done[ST_EXEC]      = exec_done;
    assign stage_done[ST_REG_W]     = reg_w_done;
    assign stage_done[ST_MEM_W]     = mem_w_done;
    assign stage_done[ST_PC_NEXT]   = pc_done;

    // ==============================
    // stages
    // ==============================

    status_seq u_status_seq (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .stage_done (stage_done),
        .status     (status)
    );

    ins_fetch u_ins_fetch (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .status     (status),
        .mem_rdata  (mem_rdata),
        .fetch_req  (fetch_req),
        .ins        (ins),
        .fetch_done (fetch_done),
        .pc_done    (pc_done)
    );

    ins_dec u_ins_dec (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .status     (status),
        .ins        (ins),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .rs1        (rs1),
        .rs2        (rs2),
        .dec        (dec),
        .dec_done   (dec_done),
        .reg_r_done (reg_r_done)
    );

    reg_file u_reg_file (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst),
        .rs1     (rs1),
        .rs2     (rs2),
        .wb      (wb),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    mem_access u_mem_access (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .status     (status),
        .dec        (dec),
        .fetch_req  (fetch_req),
        .store      (store),
        .mem_rdata  (mem_rdata),
        .mem_req    (mem_req),
        .load_val   (load_val),
        .mem_r_done (mem_r_done),
        .mem_w_done (mem_w_done)
    );

    ins_exec u_ins_exec (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .status     (status),
        .dec        (dec),
        .load_val   (load_val),
        .wb         (wb),
        .store      (store),
        .exec_done  (exec_done),
        .reg_w_done (reg_w_done)
    );

endmodule

/* hdl/ins_exec.sv */
`timescale 1ns/1ps

module ins_exec (
    input  logic                      sys_clk,
    input  logic                      sys_rst,
    input  cpu_pkg::status_t          status,
    input  cpu_pkg::dec_t             dec,
    input  logic [cpu_pkg::XLEN-1:0]  load_val,
    output cpu_pkg::wb_t              wb,
    output cpu_pkg::st_rec_t          store,
    output logic                      exec_done,
    output logic                      reg_w_done
);

    import cpu_pkg::*;

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    wb_t             wb_nxt;
    wb_t             wb_q;
    st_rec_t         st_nxt;

    // ==============================
    // ALU
    // ==============================

    assign op_b = (dec.opcode == OPC_OP) ? dec.rs2_val : dec.imm;

    always_comb begin
        case (dec.funct3)
            F3_ADD: begin
                if (dec.opcode == OPC_OP && dec.alt) begin
                    alu_res = dec.rs1_val - op_b;
                end else begin
                    alu_res = dec.rs1_val + op_b;
                end
            end
            F3_SLL:  alu_res = dec.rs1_val << op_b[4:0];
            F3_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(dec.rs1_val) < $signed(op_b)};
            F3_XOR:  alu_res = dec.rs1_val ^ op_b;
            F3_SRL:  alu_res = dec.rs1_val >> op_b[4:0];
            F3_OR:   alu_res = dec.rs1_val | op_b;
            F3_AND:  alu_res = dec.rs1_val & op_b;
            default: alu_res = '0;
        endcase
    end

    // ==============================
    // write-back and store records
    // ==============================

    always_comb begin
        wb_nxt     = '0;
        wb_nxt.idx = dec.rd;
        st_nxt     = '0;
        case (dec.opcode)
            OPC_OP, OPC_OP_IMM: begin
                wb_nxt.en  = 1'b1;
                wb_nxt.val = alu_res;
            end
            OPC_LUI: begin
                wb_nxt.en  = 1'b1;
                wb_nxt.val = dec.imm;
            end
            OPC_LOAD: begin
                wb_nxt.en  = 1'b1;
                wb_nxt.val = load_val;
            end
            OPC_STORE: begin
                st_nxt.en   = 1'b1;
                st_nxt.addr = dec.rs1_val + dec.imm;
                st_nxt.val  = dec.rs2_val;
            end
            default: begin
                // anything else retires as a no-op
                wb_nxt.en = 1'b0;
            end
        endcase
    end

    assign exec_done  = (status == ST_EXEC);
    assign reg_w_done = (status == ST_REG_W);

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            wb_q  <= '0;
            store <= '0;
        end else if (exec_done) begin
            wb_q  <= wb_nxt;
            store <= st_nxt;
        end
    end

    // regfile sees the write only in REG_W
    assign wb = reg_w_done ? wb_q : '0;

endmodule

/* hdl/mem_access.sv */
`timescale 1ns/1ps

module mem_access (
    input  logic                      sys_clk,
    input  logic                      sys_rst,
    input  cpu_pkg::status_t          status,
    input  cpu_pkg::dec_t             dec,
    input  cpu_pkg::mem_req_t         fetch_req,
    input  cpu_pkg::st_rec_t          store,
    input  logic [cpu_pkg::XLEN-1:0]  mem_rdata,
    output cpu_pkg::mem_req_t         mem_req,
    output logic [cpu_pkg::XLEN-1:0]  load_val,
    output logic                      mem_r_done,
    output logic                      mem_w_done
);

    import cpu_pkg::*;

    mem_req_t own_req;
    logic     is_load;
    logic     rd_wait;

    assign is_load = (dec.opcode == OPC_LOAD);

    always_comb begin
        own_req = '0;
        if (status == ST_MEM_R && is_load && !rd_wait) begin
            own_req.en   = 1'b1;
            own_req.addr = dec.rs1_val + dec.imm;
        end else if (status == ST_MEM_W && store.en) begin
            own_req.en    = 1'b1;
            own_req.we    = 1'b1;
            own_req.addr  = store.addr;
            own_req.wdata = store.val;
        end
    end

    // idle stages drive zero, so OR is enough
    assign mem_req = mem_req_t'(fetch_req | own_req);

    assign mem_r_done = (status == ST_MEM_R) && (!is_load || rd_wait);
    assign mem_w_done = (status == ST_MEM_W);

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            rd_wait <= 1'b0;
        end else begin
            rd_wait <= (status == ST_MEM_R) && is_load && !rd_wait;
        end
    end

    // load data valid one cycle after the request
    always_ff @(posedge sys_clk) begin
        if (status == ST_MEM_R && is_load && rd_wait) begin
            load_val <= mem_rdata;
        end
    end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                           sys_clk,
    input  logic                           sys_rst,
    input  logic [cpu_pkg::REG_IDX_W-1:0]  rs1,
    input  logic [cpu_pkg::REG_IDX_W-1:0]  rs2,
    input  cpu_pkg::wb_t                   wb,
    output logic [cpu_pkg::XLEN-1:0]       rs1_val,
    output logic [cpu_pkg::XLEN-1:0]       rs2_val
);

    import cpu_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.idx != '0) begin
            regs[wb.idx] <= wb.val;
        end
    end

    // x0 reads as zero
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hdl/ins_dec.sv */
`timescale 1ns/1ps

module ins_dec (
    input  logic                           sys_clk,
    input  logic                           sys_rst,
    input  cpu_pkg::status_t               status,
    input  cpu_pkg::ins_word_u             ins,
    input  logic [cpu_pkg::XLEN-1:0]       rs1_val,
    input  logic [cpu_pkg::XLEN-1:0]       rs2_val,
    output logic [cpu_pkg::REG_IDX_W-1:0]  rs1,
    output logic [cpu_pkg::REG_IDX_W-1:0]  rs2,
    output cpu_pkg::dec_t                  dec,
    output logic                           dec_done,
    output logic                           reg_r_done
);

    import cpu_pkg::*;

    logic [XLEN-1:0] imm_ext;

    // pick the format from the opcode
    always_comb begin
        rs1     = ins.i.rs1;
        rs2     = '0;
        imm_ext = '0;
        case (ins.r.opcode)
            OPC_OP: begin
                rs2 = ins.r.rs2;
            end
            OPC_OP_IMM, OPC_LOAD: begin
                imm_ext = {{(XLEN-12){ins.i.imm_11_0[11]}}, ins.i.imm_11_0};
            end
            OPC_STORE: begin
                rs2     = ins.s.rs2;
                imm_ext = {{(XLEN-12){ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
            end
            OPC_LUI: begin
                // upper bits overlap rs1, so no read
                rs1     = '0;
                imm_ext = {ins.u.imm_31_12, 12'd0};
            end
            default: begin
                rs2 = '0;
            end
        endcase
    end

    assign dec_done   = (status == ST_INS_DEC);
    assign reg_r_done = (status == ST_REG_R);

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            dec <= '0;
        end else if (dec_done) begin
            dec.opcode <= ins.r.opcode;
            dec.funct3 <= ins.r.funct3;
            dec.alt    <= ins.r.funct7[5];
            dec.rd     <= ins.r.rd;
            dec.imm    <= imm_ext;
        end else if (reg_r_done) begin
            dec.rs1_val <= rs1_val;
            dec.rs2_val <= rs2_val;
        end
    end

endmodule

/* hdl/ins_fetch.sv */
`timescale 1ns/1ps

module ins_fetch (
    input  logic                      sys_clk,
    input  logic                      sys_rst,
    input  cpu_pkg::status_t          status,
    input  logic [cpu_pkg::XLEN-1:0]  mem_rdata,
    output cpu_pkg::mem_req_t         fetch_req,
    output cpu_pkg::ins_word_u        ins,
    output logic                      fetch_done,
    output logic                      pc_done
);

    import cpu_pkg::*;

    logic [XLEN-1:0] pc;
    logic            rd_wait;

    // first FETCH cycle requests, second one captures
    always_comb begin
        fetch_req = '0;
        if (status == ST_INS_FETCH && !rd_wait) begin
            fetch_req.en   = 1'b1;
            fetch_req.addr = pc;
        end
    end

    assign fetch_done = (status == ST_INS_FETCH) && rd_wait;
    assign pc_done    = (status == ST_PC_NEXT);

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            pc      <= RESET_PC;
            rd_wait <= 1'b0;
        end else begin
            rd_wait <= (status == ST_INS_FETCH) && !rd_wait;
            if (pc_done) begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (fetch_done) begin
            ins <= mem_rdata;
        end
    end

endmodule

/* hdl/status_seq.sv */
`timescale 1ns/1ps

module status_seq (
    input  logic              sys_clk,
    input  logic              sys_rst,
    input  logic [7:0]        stage_done,
    output cpu_pkg::status_t  status
);

    import cpu_pkg::*;

    status_t status_nxt;

    // fixed order, PC_NEXT wraps back to FETCH
    always_comb begin
        case (status)
            ST_INS_FETCH: status_nxt = ST_INS_DEC;
            ST_INS_DEC:   status_nxt = ST_REG_R;
            ST_REG_R:     status_nxt = ST_MEM_R;
            ST_MEM_R:     status_nxt = ST_EXEC;
            ST_EXEC:      status_nxt = ST_REG_W;
            ST_REG_W:     status_nxt = ST_MEM_W;
            ST_MEM_W:     status_nxt = ST_PC_NEXT;
            default:      status_nxt = ST_INS_FETCH;
        endcase
    end

    // step only on the done bit of the current status
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            status <= ST_INS_FETCH;
        end else if (stage_done[status]) begin
            status <= status_nxt;
        end
    end

endmodule

/* common/cpu_pkg.sv */
package cpu_pkg;

    // ==============================
    // widths and sizes
    // ==============================

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int REG_COUNT = 32;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // ==============================
    // encodings
    // ==============================

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // one status per step of an instruction, in order
    typedef enum logic [2:0] {
        ST_INS_FETCH = 3'd0,
        ST_INS_DEC   = 3'd1,
        ST_REG_R     = 3'd2,
        ST_MEM_R     = 3'd3,
        ST_EXEC      = 3'd4,
        ST_REG_W     = 3'd5,
        ST_MEM_W     = 3'd6,
        ST_PC_NEXT   = 3'd7
    } status_t;

    // ==============================
    // instruction formats
    // ==============================

    typedef struct packed {
        logic [6:0]           funct7;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]          imm_11_0;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]           imm_11_5;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [4:0]           imm_4_0;
        logic [6:0]           opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0]          imm_31_12;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } ins_word_u;

    // ==============================
    // stage records
    // ==============================

    typedef struct packed {
        logic [6:0]           opcode;
        logic [2:0]           funct3;
        logic                 alt;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      rs1_val;
        logic [XLEN-1:0]      rs2_val;
        logic [XLEN-1:0]      imm;
    } dec_t;

    typedef struct packed {
        logic            en;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                 en;
        logic [REG_IDX_W-1:0] idx;
        logic [XLEN-1:0]      val;
    } wb_t;

    typedef struct packed {
        logic            en;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] val;
    } st_rec_t;

endpackage
